//--- all.f
src/lc3Pkg.sv
src/regFile.sv
src/datapath.sv
src/controlUnit.sv
src/lc3Core.sv
dv/lc3Core_sva.sv
dv/lc3Tb.sv

//--- dv/lc3Core_sva.sv
//------------------------------------------------
// Bound checks on memory requests and pausing
// Every read or write lasts exactly two cycles
//------------------------------------------------
`timescale 1ns/1ps

module lc3Core_sva
(
    input logic           Clk,
    input logic           rst,
    input logic           Run,
    input logic           Paused,
    input lc3Pkg::memReqT memReq
);

    logic runSeen;       // First Run after reset
    int   failCount = 0; // Assertion failures so far

    always_ff @(posedge Clk)
    begin
        if (rst)
            runSeen <= 1'b0;
        else if (Run)
            runSeen <= 1'b1;
    end

    rdWrExclusive: assert property (@(posedge Clk) disable iff (rst)
        !(memReq.rd && memReq.wr))
        else
        begin
            $error("Read and write requested in the same cycle");
            failCount++;
        end

    rdTwoCycles: assert property (@(posedge Clk) disable iff (rst)
        $rose(memReq.rd) |=> memReq.rd ##1 !memReq.rd)
        else
        begin
            $error("Read request did not last two cycles");
            failCount++;
        end

    wrTwoCycles: assert property (@(posedge Clk) disable iff (rst)
        $rose(memReq.wr) |=> memReq.wr ##1 !memReq.wr)
        else
        begin
            $error("Write request did not last two cycles");
            failCount++;
        end

    // Address held for the whole access
    addrStable: assert property (@(posedge Clk) disable iff (rst)
        $rose(memReq.rd || memReq.wr) |=> $stable(memReq.addr))
        else
        begin
            $error("Memory address changed during an access");
            failCount++;
        end

    pauseQuiet: assert property (@(posedge Clk) disable iff (rst)
        Paused |-> !memReq.rd && !memReq.wr)
        else
        begin
            $error("Memory request while paused");
            failCount++;
        end

    haltedUntilRun: assert property (@(posedge Clk) disable iff (rst)
        !runSeen |-> !memReq.rd && !memReq.wr && !Paused)
        else
        begin
            $error("Core left the halted state before Run");
            failCount++;
        end

endmodule

bind lc3Core lc3Core_sva uSva
(
    .Clk(Clk), .rst(rst), .Run(Run), .Paused(Paused), .memReq(memReq)
);

//--- dv/lc3Tb.sv
//------------------------------------------------
// Testbench for lc3Core, also acting as its memory
// Program and expected events from dv/lc3_testdata.hex
// Memory covers word addresses 0 to 63 only
//------------------------------------------------
`timescale 1ns/1ps

module lc3Tb;

    logic                           Clk, rst, Run, Continue;
    logic [lc3Pkg::WordWidth-1:0]   memRdData;
    lc3Pkg::memReqT                 memReq;
    logic [lc3Pkg::LedWidth-1:0]    Led;
    logic                           Paused;

    logic [15:0] fileWords [0:127]; // Image, sentinel, count, events
    logic [15:0] mem [0:63];
    int          eventCount, eventIdx, eventPtr, watchdogCycles;
    int          errors, checks;
    logic        wrPrev, pausedPrev;

    lc3Core UUT
    (
        .Clk(Clk), .rst(rst), .Run(Run), .Continue(Continue), .memRdData(memRdData),
        .memReq(memReq), .Led(Led), .Paused(Paused)
    );

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic matchWrite(input logic [15:0] addr, input logic [15:0] data);
        if (eventIdx >= eventCount)
            checkTrue(1'b0, "write after the last expected event");
        else if (fileWords[eventPtr] != 16'd1)
        begin
            checkTrue(1'b0, "write where a pause was expected");
            eventPtr += 2; // Skip the pause entry
        end
        else
        begin
            checkValue("memReq.addr", addr, fileWords[eventPtr+1]);
            checkValue("memReq.wrData", data, fileWords[eventPtr+2]);
            eventPtr += 3;
        end
        eventIdx++;
    endtask

    task automatic matchPause(input logic [15:0] led);
        if (eventIdx >= eventCount)
            checkTrue(1'b0, "pause after the last expected event");
        else if (fileWords[eventPtr] != 16'd2)
        begin
            checkTrue(1'b0, "pause where a write was expected");
            eventPtr += 3;
        end
        else
        begin
            checkValue("Led", led, fileWords[eventPtr+1]);
            eventPtr += 2;
        end
        eventIdx++;
    endtask

    // Press and release with random timing
    task automatic pressContinue();
        int waitCycles;
        int holdCycles;
        waitCycles = $urandom % 5 + 1;
        holdCycles = $urandom % 5 + 1;
        repeat (waitCycles) @(negedge Clk);
        checkTrue(Paused, "Paused dropped before Continue was pressed");
        Continue = 1'b1;
        repeat (holdCycles) @(negedge Clk);
        checkTrue(Paused, "Paused dropped while Continue was held");
        Continue = 1'b0;
        @(negedge Clk);
        checkTrue(!Paused, "still paused after Continue was released");
    endtask

    //------------------------------------------------
    // Memory model and event checker
    //------------------------------------------------
    always @(negedge Clk)
    begin
        if (!rst)
        begin
            if (memReq.rd || memReq.wr)
                checkTrue(memReq.addr < 16'd64, "memory access outside the image");
            if (memReq.rd)
                memRdData = mem[memReq.addr[5:0]]; // Held until rd falls
            if (memReq.wr)
                mem[memReq.addr[5:0]] = memReq.wrData;
            if (memReq.wr && !wrPrev)
                matchWrite(memReq.addr, memReq.wrData); // One event per write
            if (Paused && !pausedPrev)
                matchPause({4'h0, Led});
        end
        wrPrev     = memReq.wr;
        pausedPrev = Paused;
    end

    initial
    begin
        int pauses;
        int ptr;
        void'($urandom(66848));
        rst        = 1'b1;
        Run        = 1'b0;
        Continue   = 1'b0;
        memRdData  = '0;
        wrPrev     = 1'b0;
        pausedPrev = 1'b0;
        errors     = 0;
        checks     = 0;
        eventIdx   = 0;
        $readmemh("dv/lc3_testdata.hex", fileWords);
        for (int i = 0; i < 64; i++)
            mem[i] = fileWords[i];
        checkValue("sentinel", fileWords[64], 16'hDEAD);
        eventCount = fileWords[65];
        eventPtr   = 66;

        // Count pauses for the watchdog budget
        pauses = 0;
        ptr    = 66;
        for (int i = 0; i < eventCount; i++)
        begin
            if (fileWords[ptr] == 16'd2)
            begin
                pauses++;
                ptr += 2;
            end
            else
                ptr += 3;
        end
        watchdogCycles = 64 * 40 + pauses * 200;

        repeat (2) @(negedge Clk);
        rst = 1'b0;
        repeat (6)
        begin
            @(negedge Clk);
            checkTrue(!memReq.rd && !memReq.wr, "memory request before Run");
            checkTrue(!Paused, "Paused high before Run");
            checkValue("Led", {4'h0, Led}, '0);
        end

        Run = 1'b1;
        @(negedge Clk);
        Run = 1'b0;
        while (eventIdx < eventCount)
        begin
            @(negedge Clk);
            if (Paused)
                pressContinue();
        end
        repeat (60) @(negedge Clk); // Catch stray writes

        checkTrue(eventIdx == eventCount, "event count differs from the data file");
        errors += UUT.uSva.failCount;
        $display("Checks: %0d, errors: %0d, events: %0d of %0d",
                 checks, errors, eventIdx, eventCount);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge Clk);
        $display("Timeout after %0d cycles with %0d of %0d events seen",
                 watchdogCycles, eventIdx, eventCount);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- dv/lc3_testdata.hex
// Words 0-63 program image, then sentinel DEAD and the event count
// Each event is 1 addr data for a write, or 2 led for a pause
601C 1265 147D 1642 58E6 5AC1 9D3F 7600
7801 7A02 7C03 642D 7404 0402 0801 720F
DA5C 4804 7E06 D3C1 0FFF 0000 7A05 C1C0
0000 0000 0000 0000 0030 8421 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000
DEAD 0009
1 0030 0007
1 0031 0006
1 0032 0005
1 0033 FFF9
1 0034 8421
2 0A5C
1 0035 0005
1 0036 0012
2 03C1

//--- src/controlUnit.sv
//------------------------------------------------
// Instruction sequencer of the LC-3 core
// Memory has a fixed access time of two cycles
// Unsupported opcodes fall back to the next fetch
// JSRR through R7 jumps to the saved return address
//------------------------------------------------
`timescale 1ns/1ps

module controlUnit
(
    input  logic             Clk,
    input  logic             rst,
    input  logic             Run,
    input  logic             Continue,
    input  lc3Pkg::decodeT   decode,
    output lc3Pkg::ctrlWordT ctrl,
    output logic             Paused
);

    lc3Pkg::stateE state, nextState;

    always_ff @(posedge Clk)
    begin
        if (rst)
            state <= lc3Pkg::sHalted;
        else
            state <= nextState;
    end

    //------------------------------------------------
    // Next state
    //------------------------------------------------
    always_comb
    begin
        nextState = state; // Hold by default
        unique case (state)
            lc3Pkg::sHalted:   if (Run) nextState = lc3Pkg::sFetchMar;
            lc3Pkg::sFetchMar: nextState = lc3Pkg::sFetchRd1;
            lc3Pkg::sFetchRd1: nextState = lc3Pkg::sFetchRd2;
            lc3Pkg::sFetchRd2: nextState = lc3Pkg::sLoadIr;
            lc3Pkg::sLoadIr:   nextState = lc3Pkg::sDecode;
            lc3Pkg::sDecode:
            begin
                case (decode.opcode)
                    lc3Pkg::opAdd: nextState = lc3Pkg::sAdd;
                    lc3Pkg::opAnd: nextState = lc3Pkg::sAnd;
                    lc3Pkg::opNot: nextState = lc3Pkg::sNot;
                    lc3Pkg::opLdr: nextState = lc3Pkg::sLdrAddr;
                    lc3Pkg::opStr: nextState = lc3Pkg::sStrAddr;
                    lc3Pkg::opJsr: nextState = lc3Pkg::sJsr;
                    lc3Pkg::opJmp: nextState = lc3Pkg::sJmp;
                    lc3Pkg::opBr:  nextState = lc3Pkg::sBr;
                    lc3Pkg::opPse: nextState = lc3Pkg::sPause1;
                    default:       nextState = lc3Pkg::sFetchMar;
                endcase
            end
            lc3Pkg::sLdrAddr: nextState = lc3Pkg::sLdrRd1;
            lc3Pkg::sLdrRd1:  nextState = lc3Pkg::sLdrRd2;
            lc3Pkg::sLdrRd2:  nextState = lc3Pkg::sLdrWb;
            lc3Pkg::sStrAddr: nextState = lc3Pkg::sStrData;
            lc3Pkg::sStrData: nextState = lc3Pkg::sStrWr1;
            lc3Pkg::sStrWr1:  nextState = lc3Pkg::sStrWr2;
            lc3Pkg::sJsr:     nextState = lc3Pkg::sJsrPc;
            lc3Pkg::sBr:      nextState = decode.ben ? lc3Pkg::sBrTaken : lc3Pkg::sFetchMar;
            lc3Pkg::sPause1:  if (Continue) nextState = lc3Pkg::sPause2;  // Wait for press
            lc3Pkg::sPause2:  if (!Continue) nextState = lc3Pkg::sFetchMar; // And release
            default:          nextState = lc3Pkg::sFetchMar; // Last cycle of every execute
        endcase
    end

    //------------------------------------------------
    // Control word
    //------------------------------------------------
    always_comb
    begin
        ctrl      = '0;
        ctrl.aluK = lc3Pkg::aluAdd;
        unique case (state)
            lc3Pkg::sFetchMar:
            begin
                ctrl.gatePc = 1'b1; // MAR <- PC, PC <- PC+1
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
            end
            lc3Pkg::sFetchRd1, lc3Pkg::sLdrRd1: ctrl.memRd = 1'b1;
            lc3Pkg::sFetchRd2, lc3Pkg::sLdrRd2:
            begin
                ctrl.memRd = 1'b1;
                ctrl.ldMdr = 1'b1;
            end
            lc3Pkg::sLoadIr:
            begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldIr    = 1'b1;
            end
            lc3Pkg::sDecode:
            begin
                ctrl.ldBen = 1'b1;
                ctrl.ldLed = (decode.opcode == lc3Pkg::opPse); // Led valid as Paused rises
            end
            lc3Pkg::sAdd, lc3Pkg::sAnd, lc3Pkg::sNot:
            begin
                ctrl.sr1Mux  = 1'b1;
                ctrl.sr2Mux  = decode.ir5;
                ctrl.gateAlu = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
                if (state == lc3Pkg::sAnd)
                    ctrl.aluK = lc3Pkg::aluAnd;
                else if (state == lc3Pkg::sNot)
                    ctrl.aluK = lc3Pkg::aluNot;
            end
            lc3Pkg::sLdrAddr, lc3Pkg::sStrAddr:
            begin
                ctrl.sr1Mux     = 1'b1; // MAR <- BaseR + off6
                ctrl.addr1Mux   = 1'b1;
                ctrl.addr2Mux   = 2'd1;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
            end
            lc3Pkg::sLdrWb:
            begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
            end
            lc3Pkg::sStrData:
            begin
                ctrl.aluK    = lc3Pkg::aluPass; // MDR <- SR from IR[11:9]
                ctrl.gateAlu = 1'b1;
                ctrl.ldMdr   = 1'b1;
            end
            lc3Pkg::sStrWr1, lc3Pkg::sStrWr2: ctrl.memWr = 1'b1;
            lc3Pkg::sJsr:
            begin
                ctrl.gatePc = 1'b1; // R7 <- PC
                ctrl.drMux  = 1'b1;
                ctrl.ldReg  = 1'b1;
            end
            lc3Pkg::sJsrPc, lc3Pkg::sJmp, lc3Pkg::sBrTaken:
            begin
                ctrl.pcMux  = 2'd2;
                ctrl.ldPc   = 1'b1;
                ctrl.sr1Mux = 1'b1;
                if (state == lc3Pkg::sBrTaken)
                    ctrl.addr2Mux = 2'd2;
                else if (state == lc3Pkg::sJsrPc && decode.ir11)
                    ctrl.addr2Mux = 2'd3; // JSR, PC-relative
                else
                    ctrl.addr1Mux = 1'b1; // JMP and JSRR take BaseR
            end
            default: ; // Halted, branch test and pause states
        endcase
    end

    assign Paused = (state == lc3Pkg::sPause1) || (state == lc3Pkg::sPause2);

endmodule

//--- src/datapath.sv
//------------------------------------------------
// LC-3 datapath around one internal bus
// Gate priority is PC, MDR, ALU, then MARMUX
// MDR takes memory data only while a read is active
//------------------------------------------------
`timescale 1ns/1ps

module datapath
(
    input  logic                              Clk,
    input  logic                              rst,
    input  lc3Pkg::ctrlWordT                  ctrl,
    input  logic [lc3Pkg::WordWidth-1:0]      memRdData,
    input  logic [lc3Pkg::WordWidth-1:0]      srcA,
    input  logic [lc3Pkg::WordWidth-1:0]      srcB,
    output lc3Pkg::memReqT                    memReq,
    output lc3Pkg::decodeT                    decode,
    output logic                              regWrEn,
    output logic [lc3Pkg::RegAddrWidth-1:0]   regDst,
    output logic [lc3Pkg::RegAddrWidth-1:0]   regSrcA,
    output logic [lc3Pkg::RegAddrWidth-1:0]   regSrcB,
    output logic [lc3Pkg::WordWidth-1:0]      regWrData,
    output logic [lc3Pkg::LedWidth-1:0]       Led
);

    logic [lc3Pkg::WordWidth-1:0] pc, mar, mdr, ir;
    logic [lc3Pkg::WordWidth-1:0] bus, aluB, aluOut, addr1, addr2, addrSum, pcNext;
    logic [lc3Pkg::WordWidth-1:0] imm5, off6, off9, off11;
    logic [2:0]                   nzp, ccNext;
    logic                         ben;

    // Sign-extended IR fields
    assign imm5  = {{(lc3Pkg::WordWidth-5){ir[4]}}, ir[4:0]};
    assign off6  = {{(lc3Pkg::WordWidth-6){ir[5]}}, ir[5:0]};
    assign off9  = {{(lc3Pkg::WordWidth-9){ir[8]}}, ir[8:0]};
    assign off11 = {{(lc3Pkg::WordWidth-11){ir[10]}}, ir[10:0]};

    //------------------------------------------------
    // ALU and address adder
    //------------------------------------------------
    assign aluB = ctrl.sr2Mux ? imm5 : srcB;

    always_comb
    begin
        unique case (ctrl.aluK)
            lc3Pkg::aluAdd:  aluOut = srcA + aluB;
            lc3Pkg::aluAnd:  aluOut = srcA & aluB;
            lc3Pkg::aluNot:  aluOut = ~srcA;
            lc3Pkg::aluPass: aluOut = srcA;
            default:         aluOut = srcA;
        endcase
    end

    assign addr1 = ctrl.addr1Mux ? srcA : pc;

    always_comb
    begin
        unique case (ctrl.addr2Mux)
            2'd0:    addr2 = '0;
            2'd1:    addr2 = off6;
            2'd2:    addr2 = off9;
            default: addr2 = off11;
        endcase
    end

    assign addrSum = addr1 + addr2;

    always_comb
    begin
        if (ctrl.gatePc)
            bus = pc;
        else if (ctrl.gateMdr)
            bus = mdr;
        else if (ctrl.gateAlu)
            bus = aluOut;
        else if (ctrl.gateMarMux)
            bus = addrSum;
        else
            bus = '0; // Nothing gated
    end

    always_comb
    begin
        case (ctrl.pcMux)
            2'd1:    pcNext = bus;
            2'd2:    pcNext = addrSum;
            default: pcNext = pc + 1'b1;
        endcase
    end

    // N, Z, P of the bus value
    assign ccNext[2] = bus[lc3Pkg::WordWidth-1];
    assign ccNext[1] = (bus == '0);
    assign ccNext[0] = ~ccNext[2] & ~ccNext[1];

    //------------------------------------------------
    // Registers
    //------------------------------------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            pc  <= '0;
            nzp <= '0;
            ben <= 1'b0;
            Led <= '0;
        end
        else
        begin
            if (ctrl.ldPc)  pc  <= pcNext;
            if (ctrl.ldCc)  nzp <= ccNext;
            if (ctrl.ldBen) ben <= |(ir[11:9] & nzp);
            if (ctrl.ldLed) Led <= ir[lc3Pkg::LedWidth-1:0];
        end
    end

    always_ff @(posedge Clk)
    begin
        if (ctrl.ldMar) mar <= bus;
        if (ctrl.ldMdr) mdr <= ctrl.memRd ? memRdData : bus;
        if (ctrl.ldIr)  ir  <= bus;
    end

    assign regWrEn   = ctrl.ldReg;
    assign regDst    = ctrl.drMux ? 3'd7 : ir[11:9]; // R7 for JSR link
    assign regSrcA   = ctrl.sr1Mux ? ir[8:6] : ir[11:9];
    assign regSrcB   = ir[2:0];
    assign regWrData = bus;

    assign memReq.addr   = mar;
    assign memReq.wrData = mdr;
    assign memReq.rd     = ctrl.memRd;
    assign memReq.wr     = ctrl.memWr;

    assign decode.opcode = lc3Pkg::opcodeE'(ir[15:12]);
    assign decode.ir5    = ir[5];
    assign decode.ir11   = ir[11];
    assign decode.ben    = ben;

endmodule

//--- src/lc3Core.sv
//------------------------------------------------
// LC-3 core top level
// Memory is word addressed with a two-cycle access
// Only one instruction is in flight at a time
//------------------------------------------------
`timescale 1ns/1ps

module lc3Core
(
    input  logic                          Clk,
    input  logic                          rst,
    input  logic                          Run,
    input  logic                          Continue,
    input  logic [lc3Pkg::WordWidth-1:0]  memRdData,
    output lc3Pkg::memReqT                memReq,
    output logic [lc3Pkg::LedWidth-1:0]   Led,
    output logic                          Paused
);

    lc3Pkg::ctrlWordT                ctrl;
    lc3Pkg::decodeT                  decode;
    logic                            regWrEn;
    logic [lc3Pkg::RegAddrWidth-1:0] regDst, regSrcA, regSrcB;
    logic [lc3Pkg::WordWidth-1:0]    regWrData, srcA, srcB;

    controlUnit uCtrl
    (
        .Clk(Clk), .rst(rst), .Run(Run), .Continue(Continue),
        .decode(decode), .ctrl(ctrl), .Paused(Paused)
    );

    datapath uDp
    (
        .Clk(Clk), .rst(rst), .ctrl(ctrl), .memRdData(memRdData),
        .srcA(srcA), .srcB(srcB), .memReq(memReq), .decode(decode),
        .regWrEn(regWrEn), .regDst(regDst), .regSrcA(regSrcA), .regSrcB(regSrcB),
        .regWrData(regWrData), .Led(Led)
    );

    regFile uRegs
    (
        .Clk(Clk), .rst(rst), .wrEn(regWrEn), .wrAddr(regDst),
        .rdAddrA(regSrcA), .rdAddrB(regSrcB), .wrData(regWrData),
        .rdDataA(srcA), .rdDataB(srcB)
    );

endmodule

//--- src/lc3Pkg.sv
//------------------------------------------------
// Shared widths, enums and structs of the LC-3 core
// Opcode values follow the standard LC-3 encoding
// Only the executed subset of opcodes is listed
//------------------------------------------------
package lc3Pkg;

    localparam int WordWidth    = 16;
    localparam int RegAddrWidth = 3;
    localparam int LedWidth     = 12;
    localparam int NumRegs      = 2 ** RegAddrWidth;

    // IR[15:12]
    typedef enum logic [3:0]
    {
        opBr  = 4'b0000,
        opAdd = 4'b0001,
        opJsr = 4'b0100,
        opAnd = 4'b0101,
        opLdr = 4'b0110,
        opStr = 4'b0111,
        opNot = 4'b1001,
        opJmp = 4'b1100,
        opPse = 4'b1101
    } opcodeE;

    // Sequencer states, LC-3 state numbers in the trailing comments
    typedef enum logic [4:0]
    {
        sHalted,
        sFetchMar, sFetchRd1, sFetchRd2, sLoadIr, sDecode, // 18, 33, 35, 32
        sAdd, sAnd, sNot,                                  // 1, 5, 9
        sLdrAddr, sLdrRd1, sLdrRd2, sLdrWb,                // 6, 25, 27
        sStrAddr, sStrData, sStrWr1, sStrWr2,              // 7, 23, 16
        sJsr, sJsrPc, sJmp, sBr, sBrTaken,                 // 4, 21, 12, 0, 22
        sPause1, sPause2
    } stateE;

    typedef enum logic [1:0]
    {
        aluAdd  = 2'b00,
        aluAnd  = 2'b01,
        aluNot  = 2'b10,
        aluPass = 2'b11
    } aluOpE;

    typedef struct packed
    {
        logic       ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
        logic       gatePc, gateMdr, gateAlu, gateMarMux;
        logic [1:0] pcMux;    // 0 PC+1, 1 bus, 2 address adder
        logic       drMux;    // 1 selects R7
        logic       sr1Mux;   // 1 selects IR[8:6], else IR[11:9]
        logic       sr2Mux;   // 1 selects imm5
        logic       addr1Mux; // 1 selects SR1, else PC
        logic [1:0] addr2Mux; // 0 zero, 1 off6, 2 off9, 3 off11
        aluOpE      aluK;
        logic       memRd, memWr;
    } ctrlWordT;

    typedef struct packed
    {
        logic [WordWidth-1:0] addr;
        logic [WordWidth-1:0] wrData;
        logic                 rd;
        logic                 wr;
    } memReqT;

    typedef struct packed
    {
        opcodeE opcode;
        logic   ir5;
        logic   ir11;
        logic   ben;
    } decodeT;

endpackage

//--- src/regFile.sv
//------------------------------------------------
// Eight general registers, cleared on reset
// Reads are combinational, a write lands at the edge
//------------------------------------------------
`timescale 1ns/1ps

module regFile
(
    input  logic                            Clk,
    input  logic                            rst,
    input  logic                            wrEn,
    input  logic [lc3Pkg::RegAddrWidth-1:0] wrAddr,
    input  logic [lc3Pkg::RegAddrWidth-1:0] rdAddrA,
    input  logic [lc3Pkg::RegAddrWidth-1:0] rdAddrB,
    input  logic [lc3Pkg::WordWidth-1:0]    wrData,
    output logic [lc3Pkg::WordWidth-1:0]    rdDataA,
    output logic [lc3Pkg::WordWidth-1:0]    rdDataB
);

    logic [lc3Pkg::WordWidth-1:0] regs [lc3Pkg::NumRegs];

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < lc3Pkg::NumRegs; i++)
                regs[i] <= '0;
        end
        else if (wrEn)
            regs[wrAddr] <= wrData;
    end

    assign rdDataA = regs[rdAddrA]; // Old value during a write to the same register
    assign rdDataB = regs[rdAddrB];

endmodule
